// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Data path width
	localparam int word_w = 32;
	// Word address width, 2048 words
	localparam int pc_w = 11;

	// Next PC source
	// Bit 0 set on every redirect, doubles as flush flag
	typedef enum logic [2:0] {
		PC_SEQ    = 3'b000,
		PC_BRANCH = 3'b001,
		PC_JUMP   = 3'b011,
		PC_REG    = 3'b101
	} pc_src_t;

	// Stops fetch once it reaches the output register
	localparam logic [word_w-1:0] halt_word = 32'hffff_ffff;

	// From the pipeline, source code plus all three targets
	typedef struct packed {
		pc_src_t         src;
		logic [pc_w-1:0] branch_target;
		logic [pc_w-1:0] jump_target;
		logic [pc_w-1:0] reg_target;
	} redirect_t;

	// Toward decode
	typedef struct packed {
		logic [word_w-1:0] instr;
		logic [pc_w-1:0]   pc;
		// Branch base, zero on a flushed slot
		logic [pc_w-1:0]   pc_plus1;
	} fetch_out_t;

	// Host strobes and levels
	typedef struct packed {
		logic              load_start;
		logic              load_write;
		logic [word_w-1:0] load_data;
		logic [pc_w-1:0]   debug_addr;
		logic              debug_mode;
		logic              run;
		logic              step;
	} host_t;

endpackage

`default_nettype wire

// File: hw/pc_select.sv
`timescale 1ns/100ps
`default_nettype none

module pc_select import fetch_pkg::*; (
	input wire clk,
	input wire reset,
	input wire redirect_t redirect,
	input wire advance,
	input wire freeze,
	output logic [pc_w-1:0] pc,
	output logic [pc_w-1:0] pc_next_seq
);

	logic [pc_w-1:0] pc_next;
	logic load;

	//////////////////////////////////////////////////////////////////////
	// Incrementer and source mux
	//////////////////////////////////////////////////////////////////////

	// Word addressed, so plus one
	assign pc_next_seq = pc + 1'b1;

	always_comb begin
		case (redirect.src)
			PC_BRANCH: begin
				pc_next = redirect.branch_target;
			end
			PC_JUMP: begin
				pc_next = redirect.jump_target;
			end
			PC_REG: begin
				pc_next = redirect.reg_target;
			end
			// Sequential, also the fallback for bad codes
			default: begin
				pc_next = pc_next_seq;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////////////////////////

	// Advance only while fetching
	// Freeze wins, halt word sits in the output
	assign load = advance & ~freeze;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (load) begin
			pc <= pc_next;
		end
	end

	// Pipeline must only send the four defined source codes
	a_src_legal: assert property (
		@(posedge clk) disable iff (reset)
		advance |-> (redirect.src inside {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG})
	) else $error("pc_select: illegal pc source code %b", redirect.src);

endmodule

`default_nettype wire

// File: hw/instr_mem.sv
`timescale 1ns/100ps
`default_nettype none

module instr_mem import fetch_pkg::*; #(
	parameter int mem_depth = 2048
) (
	input wire clk,
	input wire reset,
	input wire [pc_w-1:0] addr,
	input wire read_en,
	input wire flush,
	input wire write_en,
	input wire [pc_w-1:0] write_addr,
	input wire [word_w-1:0] write_data,
	output logic [word_w-1:0] data,
	output logic is_halt
);

	// Low address bits index the array
	localparam int addr_w = $clog2(mem_depth);

	logic [word_w-1:0] mem [mem_depth];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	// Host load path, one word per strobe
	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[write_addr[addr_w-1:0]] <= write_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////////////////////////

	// Flush turns the slot into a bubble
	// No read, output keeps last word
	always_ff @(posedge clk) begin
		if (reset) begin
			data <= '0;
		end else if (flush) begin
			data <= '0;
		end else if (read_en) begin
			data <= mem[addr[addr_w-1:0]];
		end
	end

	// Halt check on the registered word
	assign is_halt = (data == halt_word);

	// Loads only happen in debug mode, so fetch and load never overlap
	a_no_rw_overlap: assert property (
		@(posedge clk) disable iff (reset)
		!(write_en && read_en)
	) else $error("instr_mem: read and write in the same cycle");

endmodule

`default_nettype wire

// File: hw/instruction_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_fetch import fetch_pkg::*; #(
	parameter int mem_depth = 2048
) (
	input wire clk,
	input wire reset,
	input wire redirect_t redirect,
	input wire fetch_enable,
	input wire debug_mode,
	input wire [pc_w-1:0] debug_addr,
	input wire mem_write,
	input wire [pc_w-1:0] write_addr,
	input wire [word_w-1:0] write_data,
	output fetch_out_t fetch,
	output logic halt_seen
);

	logic [pc_w-1:0] pc;
	logic [pc_w-1:0] pc_next_seq;
	logic [pc_w-1:0] mem_addr;
	logic [word_w-1:0] instr;
	logic is_halt;
	logic fetch_go;
	logic flush;
	logic read_en;
	logic halt_d;
	logic [pc_w-1:0] pc_q;
	logic [pc_w-1:0] pc_plus1_q;

	//////////////////////////////////////////////////////////////////////
	// Fetch control
	//////////////////////////////////////////////////////////////////////

	// A halt word in the output stops the stage
	assign fetch_go = fetch_enable & ~is_halt;
	// Redirect flag is bit 0 of the source
	assign flush = fetch_go & redirect.src[0];
	// Debug readback uses the read port too, but not during a load
	assign read_en = (fetch_go | debug_mode) & ~mem_write;
	assign mem_addr = debug_mode ? debug_addr : pc;

	pc_select i_pc_select (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.advance(fetch_enable),
		.freeze(is_halt),
		.pc(pc),
		.pc_next_seq(pc_next_seq)
	);

	instr_mem #(
		.mem_depth(mem_depth)
	) i_instr_mem (
		.clk(clk),
		.reset(reset),
		.addr(mem_addr),
		.read_en(read_en),
		.flush(flush),
		.write_en(mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.data(instr),
		.is_halt(is_halt)
	);

	//////////////////////////////////////////////////////////////////////
	// PC tags, aligned with the memory output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			pc_plus1_q <= '0;
		end else if (fetch_go) begin
			pc_q <= pc;
			// Bubble carries no branch base
			pc_plus1_q <= flush ? '0 : pc_next_seq;
		end
	end

	// One pulse per halt word, readback excluded
	always_ff @(posedge clk) begin
		if (reset) begin
			halt_d <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			halt_d <= is_halt;
			halt_seen <= is_halt & ~halt_d & ~debug_mode;
		end
	end

	assign fetch = '{instr: instr, pc: pc_q, pc_plus1: pc_plus1_q};

endmodule

`default_nettype wire

// File: hw/fetch_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl_regs import fetch_pkg::*; (
	input wire clk,
	input wire reset,
	input wire host_t host,
	input wire stall,
	input wire halt_seen,
	output logic fetch_enable,
	output logic debug_mode,
	output logic [pc_w-1:0] debug_addr,
	output logic mem_write,
	output logic [pc_w-1:0] write_addr,
	output logic [word_w-1:0] write_data,
	output logic halted,
	output logic busy
);

	logic [pc_w-1:0] load_addr;
	logic step_pending;

	//////////////////////////////////////////////////////////////////////
	// Program load
	//////////////////////////////////////////////////////////////////////

	// Writes only accepted in debug mode
	assign mem_write = host.load_write & host.debug_mode;
	assign write_addr = load_addr;
	assign write_data = host.load_data;

	// Start rewinds, each write advances
	always_ff @(posedge clk) begin
		if (reset) begin
			load_addr <= '0;
		end else if (host.load_start) begin
			load_addr <= '0;
		end else if (mem_write) begin
			load_addr <= load_addr + 1'b1;
		end
	end

	// Readback straight from the host
	assign debug_mode = host.debug_mode;
	assign debug_addr = host.debug_addr;

	//////////////////////////////////////////////////////////////////////
	// Run, step and halt
	//////////////////////////////////////////////////////////////////////

	assign fetch_enable = (host.run | step_pending) & ~stall & ~host.debug_mode & ~halted;

	// Pending step is used up by one fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			step_pending <= 1'b0;
		end else if (host.step && !host.run) begin
			step_pending <= 1'b1;
		end else if (fetch_enable) begin
			step_pending <= 1'b0;
		end
	end

	// Sticky until the next load
	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
			busy <= 1'b0;
		end else begin
			busy <= fetch_enable;
			if (host.load_start) begin
				halted <= 1'b0;
			end else if (halt_seen) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int mem_depth = 2048
) (
	input wire clk,
	input wire reset,
	input wire host_t host,
	input wire redirect_t redirect,
	input wire stall,
	output fetch_out_t fetch,
	output logic halted,
	output logic busy
);

	// Control to fetch
	logic fetch_enable;
	logic debug_mode;
	logic [pc_w-1:0] debug_addr;
	logic mem_write;
	logic [pc_w-1:0] write_addr;
	logic [word_w-1:0] write_data;
	// Fetch back to control
	logic halt_seen;

	fetch_ctrl_regs i_fetch_ctrl_regs (
		.clk(clk),
		.reset(reset),
		.host(host),
		.stall(stall),
		.halt_seen(halt_seen),
		.fetch_enable(fetch_enable),
		.debug_mode(debug_mode),
		.debug_addr(debug_addr),
		.mem_write(mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.halted(halted),
		.busy(busy)
	);

	instruction_fetch #(
		.mem_depth(mem_depth)
	) i_instruction_fetch (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.fetch_enable(fetch_enable),
		.debug_mode(debug_mode),
		.debug_addr(debug_addr),
		.mem_write(mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.fetch(fetch),
		.halt_seen(halt_seen)
	);

endmodule

`default_nettype wire

// File: testbench/fetch_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_checker import fetch_pkg::*; (
	input wire clk,
	input wire reset,
	input wire host_t host,
	input wire redirect_t redirect,
	input wire stall,
	input wire fetch_out_t fetch,
	input wire halted,
	input wire busy,
	input wire [2:0] test_id,
	input wire test_end,
	output int error_count,
	output int check_count
);

	// Model copy of the program, filled from host writes
	logic [word_w-1:0] model_mem [2**pc_w];
	logic [pc_w-1:0] load_addr;
	logic [pc_w-1:0] model_pc;
	fetch_out_t model_out;
	logic step_pending;
	logic model_halted;
	logic model_busy;
	logic halt_d;
	logic halt_seen;
	int test_errors;
	int test_checks;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0: return "load_seq";
			3'd1: return "redirect";
			3'd2: return "stall";
			3'd3: return "step_debug";
			3'd4: return "halt";
			default: return "idle";
		endcase
	endfunction

	// Expected stage output after one clock edge
	function automatic fetch_out_t expected_fetch(input fetch_out_t cur, input logic fetching,
			input logic redirecting, input logic reading, input logic [pc_w-1:0] addr,
			input logic [pc_w-1:0] pc_now);
		fetch_out_t nxt;
		nxt = cur;
		// Redirect slot is a bubble
		if (redirecting) begin
			nxt.instr = '0;
		end else if (reading) begin
			nxt.instr = model_mem[addr];
		end
		if (fetching) begin
			nxt.pc = pc_now;
			nxt.pc_plus1 = redirecting ? '0 : pc_now + 1'b1;
		end
		return nxt;
	endfunction

	function automatic logic [pc_w-1:0] next_pc(input redirect_t r, input logic [pc_w-1:0] pc_now);
		case (r.src)
			PC_BRANCH: return r.branch_target;
			PC_JUMP: return r.jump_target;
			PC_REG: return r.reg_target;
			default: return pc_now + 1'b1;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model, stepped on the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : model_step
		logic enable;
		logic fetching;
		logic redirecting;
		logic reading;
		logic writing;
		logic at_halt;
		logic [pc_w-1:0] addr;
		if (reset) begin
			load_addr = '0;
			model_pc = '0;
			model_out = '0;
			step_pending = 1'b0;
			model_halted = 1'b0;
			model_busy = 1'b0;
			halt_d = 1'b0;
			halt_seen = 1'b0;
		end else begin
			enable = (host.run | step_pending) & ~stall & ~host.debug_mode & ~model_halted;
			at_halt = (model_out.instr == halt_word);
			fetching = enable & ~at_halt;
			redirecting = fetching & (redirect.src != PC_SEQ);
			writing = host.load_write & host.debug_mode;
			reading = (fetching | host.debug_mode) & ~writing;
			addr = host.debug_mode ? host.debug_addr : model_pc;
			model_out = expected_fetch(model_out, fetching, redirecting, reading, addr, model_pc);
			if (fetching) begin
				model_pc = next_pc(redirect, model_pc);
			end
			// Host load path
			if (writing) begin
				model_mem[load_addr] = host.load_data;
			end
			if (host.load_start) begin
				load_addr = '0;
			end else if (writing) begin
				load_addr = load_addr + 1'b1;
			end
			if (host.step && !host.run) begin
				step_pending = 1'b1;
			end else if (enable) begin
				step_pending = 1'b0;
			end
			// Sticky halt, old pulse sets it
			if (host.load_start) begin
				model_halted = 1'b0;
			end else if (halt_seen) begin
				model_halted = 1'b1;
			end
			halt_seen = at_halt & ~halt_d & ~host.debug_mode;
			halt_d = at_halt;
			model_busy = enable;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Comparison on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		test_checks++;
		if (expected !== actual) begin
			error_count++;
			test_errors++;
			$display("Fail %s: %s expected %h actual %h", test_name(test_id), what,
				expected, actual);
		end
	endtask

	always @(negedge clk) begin
		if (reset) begin
			error_count = 0;
			check_count = 0;
			test_errors = 0;
			test_checks = 0;
		end else begin
			compare_value("fetch", 64'(model_out), 64'(fetch));
			compare_value("halted", 64'(model_halted), 64'(halted));
			compare_value("busy", 64'(model_busy), 64'(busy));
			// Per test summary line
			if (test_end) begin
				$display("Test %s finished, %0d checks, %0d errors", test_name(test_id),
					test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	localparam int n_words = 40;
	// Cycles per test: reset, load_seq, redirect, stall, step_debug, halt
	localparam int test_cycles = 4 + (n_words + 16) + 16 + 11 + 15 + 14;
	localparam int timeout_cycles = 2 * test_cycles;

	logic clk = 1'b0;
	logic reset;
	host_t host;
	redirect_t redirect;
	logic stall;
	fetch_out_t fetch;
	logic halted;
	logic busy;
	logic [2:0] test_id;
	logic test_end;
	int error_count;
	int check_count;
	int cycle = 0;
	logic [word_w-1:0] prog [n_words];

	// 100 ns clock
	always #50 clk = ~clk;

	fetch_top #(
		.mem_depth(2048)
	) i_fetch_top (
		.clk(clk),
		.reset(reset),
		.host(host),
		.redirect(redirect),
		.stall(stall),
		.fetch(fetch),
		.halted(halted),
		.busy(busy)
	);

	fetch_checker i_fetch_checker (
		.clk(clk),
		.reset(reset),
		.host(host),
		.redirect(redirect),
		.stall(stall),
		.fetch(fetch),
		.halted(halted),
		.busy(busy),
		.test_id(test_id),
		.test_end(test_end),
		.error_count(error_count),
		.check_count(check_count)
	);

	// Watchdog
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the test sequence never finished", cycle);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers, drives land 10 ns after the edge
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic run_cycles(input int n);
		repeat (n) tick();
	endtask

	// Random program, halt words only where placed
	task automatic fill_program();
		for (int k = 0; k < n_words; k++) begin
			prog[k] = $urandom;
			if (prog[k] == halt_word) begin
				prog[k] = '0;
			end
		end
		prog[30] = halt_word;
		prog[38] = halt_word;
	endtask

	// Rewind outside debug mode, so no unwritten word is read back
	task automatic load_program();
		host.load_start = 1'b1;
		tick();
		host.load_start = 1'b0;
		host.debug_mode = 1'b1;
		host.load_write = 1'b1;
		for (int k = 0; k < n_words; k++) begin
			host.load_data = prog[k];
			tick();
		end
		host.load_write = 1'b0;
		host.debug_mode = 1'b0;
	endtask

	task automatic redirect_once(input pc_src_t src);
		redirect.src = src;
		tick();
		redirect.src = PC_SEQ;
	endtask

	task automatic end_test();
		test_end = 1'b1;
		tick();
		test_end = 1'b0;
		test_id = test_id + 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h5f3c));
		reset = 1'b1;
		host = '0;
		redirect = '{src: PC_SEQ, branch_target: 11'd20, jump_target: 11'd5, reg_target: 11'd12};
		stall = 1'b0;
		test_id = '0;
		test_end = 1'b0;
		fill_program();
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		tick();
		// Load and sequential run, words 0 to 11
		load_program();
		host.run = 1'b1;
		run_cycles(12);
		host.run = 1'b0;
		run_cycles(2);
		end_test();
		// Branch, jump and register redirects
		host.run = 1'b1;
		run_cycles(2);
		redirect_once(PC_BRANCH);
		run_cycles(3);
		redirect_once(PC_JUMP);
		run_cycles(3);
		redirect_once(PC_REG);
		run_cycles(3);
		host.run = 1'b0;
		tick();
		end_test();
		// Back-pressure
		host.run = 1'b1;
		run_cycles(2);
		stall = 1'b1;
		run_cycles(4);
		stall = 1'b0;
		run_cycles(3);
		host.run = 1'b0;
		tick();
		end_test();
		// Three single steps, then readback of two words
		repeat (3) begin
			host.step = 1'b1;
			tick();
			host.step = 1'b0;
			run_cycles(2);
		end
		host.debug_mode = 1'b1;
		host.debug_addr = 11'd3;
		run_cycles(2);
		host.debug_addr = 11'd17;
		run_cycles(2);
		host.debug_mode = 1'b0;
		tick();
		end_test();
		// Jump near the halt word at 30 and wait for halted
		redirect.jump_target = 11'd27;
		host.run = 1'b1;
		redirect_once(PC_JUMP);
		while (!halted) begin
			tick();
		end
		run_cycles(3);
		host.run = 1'b0;
		host.load_start = 1'b1;
		tick();
		host.load_start = 1'b0;
		run_cycles(2);
		end_test();
		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/fetch_pkg.sv
hw/pc_select.sv
hw/instr_mem.sv
hw/instruction_fetch.sv
hw/fetch_ctrl_regs.sv
hw/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

// File: Makefile
# Build and run the fetch stage testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module fetch_tb -Mdir obj_dir -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
